// ==== rf_subsys_top.f ====
rtl/rf_map_pkg.sv
rtl/eu_pkg.sv
rtl/rmio_intf.sv
rtl/bram_intf.sv
rtl/rf_sync_ram.sv
rtl/stmm_unit.sv
rtl/mean_center_unit.sv
rtl/rf_ram.sv
rtl/rf_subsys_top.sv
test/tb_clk_gen.sv
test/tb_rf_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the register-file testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
EXE=tb_rf_subsys_sim

verilator --binary --timing \
    -f rf_subsys_top.f \
    --top-module tb_rf_subsys \
    -Mdir "${BUILD_DIR}" \
    -o "${EXE}"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$("./${BUILD_DIR}/${EXE}" 2>&1)
sim_status=$?
echo "${sim_out}"
if [ ${sim_status} -ne 0 ]; then
    echo "Simulation exited with status ${sim_status}"
    exit 1
fi

if echo "${sim_out}" | grep -qxF "Test completed successfully"; then
    exit 0
else
    exit 1
fi

// ==== test/tb_rf_subsys.sv ====
`timescale 1ns/1ps

module tb_rf_subsys import rf_map_pkg::*, eu_pkg::*; ();

    localparam int RST_CYCLES = 4;
    localparam int RAM_WORDS  = 512;
    localparam int N_RAM      = 300;
    localparam int N_ROUNDS   = 20;
    localparam int N_NOEFF    = 32;
    localparam int N_MIXED    = 200;

    // Every phase plus a full RAM readback and slack
    localparam int TIMEOUT_CYCLES = RST_CYCLES + 2 * LANES + N_RAM
        + 2 * N_ROUNDS * (2 * LANES + 1) + N_NOEFF + RAM_WORDS
        + 2 * LANES + N_MIXED + 200;

    logic     clk;
    logic     rst_n;
    rf_addr_t addr;
    rf_word_t wdata;
    logic     we;
    logic     re;
    rf_word_t rdata;

    int seed = 56;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    // Reference model state
    rf_word_t ram_m [RAM_WORDS];
    bit       ram_valid [RAM_WORDS];
    int       ram_addrs [$];
    rf_word_t stmm_rows [LANES];
    rf_word_t mc_vecs [LANES];

    // Expected read data, one entry per read in flight
    rf_word_t exp_q [$];
    rf_addr_t exp_addr_q [$];

    tb_clk_gen #(
        .HALF_NS    (4),
        .RST_CYCLES (RST_CYCLES)
    ) i_tb_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rf_subsys_top #(
        .RAM_ADDR_W (9)
    ) i_rf_subsys_top (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (addr),
        .wdata (wdata),
        .we    (we),
        .re    (re),
        .rdata (rdata)
    );

    //////////////////////////////
    // Random helpers
    //////////////////////////////
    function automatic int pick(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic rf_word_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    //////////////////////////////
    // Model arithmetic
    //////////////////////////////

    // Sign-extended element k of a word
    function automatic int elem_val(input rf_word_t w, input int k);
        elem_t e;
        e = w[k];
        return int'(e);
    endfunction

    // Row i of the tile times the tile, kept mod 2^16
    function automatic rf_word_t square_row(input int i);
        int       acc;
        rf_word_t res;
        for (int j = 0; j < ELEMS; j++) begin
            acc = 0;
            for (int k = 0; k < LANES; k++) begin
                acc += elem_val(stmm_rows[i], k) * elem_val(stmm_rows[k], j);
            end
            res[j] = elem_t'(acc);
        end
        return res;
    endfunction

    // Vector i minus its floored mean
    function automatic rf_word_t center_vec(input int i);
        int       sum;
        int       mean;
        rf_word_t res;
        sum = 0;
        for (int j = 0; j < ELEMS; j++) begin
            sum += elem_val(mc_vecs[i], j);
        end
        mean = sum >>> 2;
        for (int j = 0; j < ELEMS; j++) begin
            res[j] = elem_t'(elem_val(mc_vecs[i], j) - mean);
        end
        return res;
    endfunction

    // Any X or Y register of either unit
    function automatic bit is_unit_reg(input rf_addr_t a);
        return (a >= ADDR_STMM_X0 && a <= ADDR_STMM_X3)
            || (a >= ADDR_STMM_Y0 && a <= ADDR_STMM_Y3)
            || (a >= ADDR_MC_X0 && a <= ADDR_MC_X3)
            || (a >= ADDR_MC_Y0 && a <= ADDR_MC_Y3);
    endfunction

    //////////////////////////////
    // Bus access and checking
    //////////////////////////////
    task automatic check_word(input string name, input rf_word_t got, input rf_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // One host cycle, starting 1 ns after an edge
    task automatic access(input rf_addr_t a, input rf_word_t d, input logic w, input logic r,
                          input rf_word_t exp);
        rf_word_t exp_w;
        rf_addr_t exp_a;
        addr  = a;
        wdata = d;
        we    = w;
        re    = r;
        if (r) begin
            exp_q.push_back(exp);
            exp_addr_q.push_back(a);
        end
        @(posedge clk);
        #1;
        // Read data of this access is now on rdata
        if (exp_q.size() > 0) begin
            exp_w = exp_q.pop_front();
            exp_a = exp_addr_q.pop_front();
            check_word($sformatf("rdata (addr 0x%h)", exp_a), rdata, exp_w);
        end
    endtask

    task automatic idle_cycle();
        access('0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic write_reg(input rf_addr_t a, input rf_word_t d);
        access(a, d, 1'b1, 1'b0, '0);
    endtask

    task automatic read_reg(input rf_addr_t a, input rf_word_t exp);
        access(a, '0, 1'b0, 1'b1, exp);
    endtask

    task automatic ram_write(input int a, input rf_word_t d);
        write_reg(rf_addr_t'(a), d);
        if (!ram_valid[a]) begin
            ram_valid[a] = 1'b1;
            ram_addrs.push_back(a);
        end
        ram_m[a] = d;
    endtask

    task automatic ram_read(input int a);
        read_reg(rf_addr_t'(a), ram_m[a]);
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin
        int       lane;
        int       a;
        rf_word_t d;
        rf_addr_t ha;
        addr  = '0;
        wdata = '0;
        we    = 1'b0;
        re    = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            stmm_rows[i] = '0;
            mc_vecs[i]   = '0;
        end
        wait (rst_n === 1'b1);

        // Results are zero straight out of reset
        for (int i = 0; i < LANES; i++) begin
            read_reg(rf_addr_t'(ADDR_STMM_Y0 + i), '0);
            read_reg(rf_addr_t'(ADDR_MC_Y0 + i), '0);
        end

        // RAM traffic, reads only hit written words
        for (int n = 0; n < N_RAM; n++) begin
            if (ram_addrs.size() == 0 || pick(2) == 0) begin
                ram_write(pick(RAM_WORDS), rand_word());
            end else begin
                ram_read(ram_addrs[pick(ram_addrs.size())]);
            end
        end

        // Square-tile rounds
        for (int n = 0; n < N_ROUNDS; n++) begin
            for (int i = 0; i < LANES; i++) begin
                d = rand_word();
                write_reg(rf_addr_t'(ADDR_STMM_X0 + i), d);
                stmm_rows[i] = d;
            end
            idle_cycle();
            for (int i = 0; i < LANES; i++) begin
                read_reg(rf_addr_t'(ADDR_STMM_Y0 + i), square_row(i));
            end
        end

        // Mean-centering rounds
        for (int n = 0; n < N_ROUNDS; n++) begin
            for (int i = 0; i < LANES; i++) begin
                d = rand_word();
                write_reg(rf_addr_t'(ADDR_MC_X0 + i), d);
                mc_vecs[i] = d;
            end
            idle_cycle();
            for (int i = 0; i < LANES; i++) begin
                read_reg(rf_addr_t'(ADDR_MC_Y0 + i), center_vec(i));
            end
        end

        // Writes to Y registers and holes must be dropped
        for (int n = 0; n < N_NOEFF; n++) begin
            if (pick(2) == 0) begin
                lane = pick(LANES);
                ha   = (pick(2) == 0) ? rf_addr_t'(ADDR_STMM_Y0 + lane)
                                      : rf_addr_t'(ADDR_MC_Y0 + lane);
            end else begin
                do begin
                    ha = rf_addr_t'(RAM_WORDS + pick(RAM_WORDS));
                end while (is_unit_reg(ha));
            end
            write_reg(ha, rand_word());
        end
        foreach (ram_addrs[i]) begin
            ram_read(ram_addrs[i]);
        end
        for (int i = 0; i < LANES; i++) begin
            read_reg(rf_addr_t'(ADDR_STMM_Y0 + i), square_row(i));
            read_reg(rf_addr_t'(ADDR_MC_Y0 + i), center_vec(i));
        end

        // Mixed back-to-back reads across all sources
        for (int n = 0; n < N_MIXED; n++) begin
            lane = pick(LANES);
            case (pick(3))
                0: begin
                    a = ram_addrs[pick(ram_addrs.size())];
                    ram_read(a);
                end
                1:       read_reg(rf_addr_t'(ADDR_STMM_Y0 + lane), square_row(lane));
                default: read_reg(rf_addr_t'(ADDR_MC_Y0 + lane), center_vec(lane));
            endcase
        end
        idle_cycle();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    //////////////////////////////
    // Watchdog
    //////////////////////////////
    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Test failed");
            $finish;
        end
    end

endmodule

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_NS    = 4,
    parameter int RST_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    // Free-running clock, 8 ns period by default
    initial begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;
    end

    // Reset low for the first edges, released just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== rtl/rf_subsys_top.sv ====
`timescale 1ns/1ps

module rf_subsys_top import rf_map_pkg::*, eu_pkg::*; #(
    parameter int RAM_ADDR_W = 9
) (
    input  logic     clk,
    input  logic     rst_n,
    input  rf_addr_t addr,
    input  rf_word_t wdata,
    input  logic     we,
    input  logic     re,
    output rf_word_t rdata
);

    //////////////////////////////
    // Bundles
    //////////////////////////////

    // Full host space
    bram_intf #(.ADDR_W(RF_ADDR_W)) host_bus ();

    // RAM half only
    bram_intf #(.ADDR_W(RAM_ADDR_W)) ram_bus ();

    rmio_intf stmm_io ();
    rmio_intf mc_io ();

    // Host pins onto the host bundle
    assign host_bus.addr = addr;
    assign host_bus.data = wdata;
    assign host_bus.we   = we;
    assign host_bus.re   = re;
    assign rdata         = host_bus.q;

    //////////////////////////////
    // Register file and storage
    //////////////////////////////
    rf_ram #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) i_rf_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .host      (host_bus),
        .mem       (ram_bus),
        .rmio_stmm (stmm_io),
        .rmio_mc   (mc_io)
    );

    rf_sync_ram #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) i_rf_sync_ram (
        .clk  (clk),
        .port (ram_bus)
    );

    // Execution units
    stmm_unit i_stmm_unit (
        .clk   (clk),
        .rst_n (rst_n),
        .rmio  (stmm_io)
    );

    mean_center_unit i_mean_center_unit (
        .clk   (clk),
        .rst_n (rst_n),
        .rmio  (mc_io)
    );

endmodule

// ==== rtl/rf_ram.sv ====
`timescale 1ns/1ps

module rf_ram import rf_map_pkg::*, eu_pkg::*; #(
    parameter int RAM_ADDR_W = 9
) (
    input logic     clk,
    input logic     rst_n,
    bram_intf.mem   host,
    bram_intf.host  mem,
    rmio_intf.rf    rmio_stmm,
    rmio_intf.rf    rmio_mc
);

    localparam int RAM_WORDS = 2**RAM_ADDR_W;

    // Decode of the current access
    rf_region_e acc_region;
    lane_mask_t lane_oh;

    // Write strobes before the register stage
    lane_mask_t stmm_we_d;
    lane_mask_t mc_we_d;

    // Write data toward both units
    rf_word_t   wdata_q;

    // Address of the access issued last cycle
    rf_addr_t   addr_q;
    rf_region_e rd_region;

    //////////////////////////////
    // Access decode
    //////////////////////////////
    always_comb begin
        acc_region = rf_region(host.addr);
        // Anything unmapped but below RAM size goes to the RAM
        if (acc_region == RGN_NONE && int'(host.addr) < RAM_WORDS) begin
            acc_region = RGN_RAM;
        end
    end

    // Lane from the low address bits
    assign lane_oh = lane_mask_t'(1) << host.addr[1:0];

    //////////////////////////////
    // Write path
    //////////////////////////////
    always_comb begin
        stmm_we_d = '0;
        mc_we_d   = '0;
        mem.we    = 1'b0;
        if (host.we) begin
            case (acc_region)
                RGN_STMM_X: stmm_we_d = lane_oh;
                RGN_MC_X:   mc_we_d   = lane_oh;
                RGN_RAM:    mem.we    = 1'b1;
                // Y registers and holes drop the write
                default:    ;
            endcase
        end
    end

    // Unit writes land one cycle late
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wdata_q            <= '0;
            rmio_stmm.input_we <= '0;
            rmio_mc.input_we   <= '0;
        end else begin
            wdata_q            <= host.data;
            rmio_stmm.input_we <= stmm_we_d;
            rmio_mc.input_we   <= mc_we_d;
        end
    end

    assign rmio_stmm.input_data = wdata_q;
    assign rmio_mc.input_data   = wdata_q;

    // RAM sees the host word directly
    assign mem.addr = host.addr[RAM_ADDR_W-1:0];
    assign mem.data = host.data;

    //////////////////////////////
    // Read strobes
    //////////////////////////////
    always_comb begin
        rmio_stmm.output_re = '0;
        rmio_mc.output_re   = '0;
        mem.re              = 1'b0;
        if (host.re) begin
            case (acc_region)
                RGN_STMM_Y: rmio_stmm.output_re = lane_oh;
                RGN_MC_Y:   rmio_mc.output_re   = lane_oh;
                RGN_RAM:    mem.re              = 1'b1;
                default:    ;
            endcase
        end
    end

    //////////////////////////////
    // Read data select
    //////////////////////////////

    // Tracks the RAM read latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else begin
            addr_q <= host.addr;
        end
    end

    assign rd_region = rf_region(addr_q);

    always_comb begin
        case (rd_region)
            RGN_STMM_Y: host.q = rmio_stmm.output_data;
            RGN_MC_Y:   host.q = rmio_mc.output_data;
            // RAM and anything unreadable
            default:    host.q = mem.q;
        endcase
    end

endmodule

// ==== rtl/mean_center_unit.sv ====
`timescale 1ns/1ps

module mean_center_unit import eu_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    rmio_intf.eu rmio
);

    // Operand vectors
    rf_word_t vec_q [LANES];

    // Vector picked by the read strobe
    rf_word_t vec_sel;

    // Sum and mean at 18 bits, no overflow for four elements
    logic signed [17:0] sum;
    logic signed [17:0] mean;

    // Centered vector before capture
    rf_word_t res_d;

    //////////////////////////////
    // Vector storage
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < LANES; i++) begin
                vec_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < LANES; i++) begin
                if (rmio.input_we[i]) begin
                    vec_q[i] <= rmio.input_data;
                end
            end
        end
    end

    always_comb begin
        vec_sel = '0;
        for (int i = 0; i < LANES; i++) begin
            if (rmio.output_re[i]) begin
                vec_sel = vec_sel | vec_q[i];
            end
        end
    end

    //////////////////////////////
    // Mean and subtraction
    //////////////////////////////
    always_comb begin
        sum = '0;
        for (int j = 0; j < ELEMS; j++) begin
            sum = sum + 18'($signed(vec_sel[j]));
        end
        // Floor division by four
        mean = sum >>> 2;
        for (int j = 0; j < ELEMS; j++) begin
            res_d[j] = elem_t'(18'($signed(vec_sel[j])) - mean);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rmio.output_data <= '0;
        end else if (|rmio.output_re) begin
            rmio.output_data <= res_d;
        end
    end

endmodule

// ==== rtl/stmm_unit.sv ====
`timescale 1ns/1ps

module stmm_unit import eu_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    rmio_intf.eu rmio
);

    // Tile rows
    rf_word_t row_q [LANES];

    // Row picked by the read strobe
    rf_word_t row_sel;

    // Result row before capture
    rf_word_t res_d;

    //////////////////////////////
    // Row storage
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < LANES; i++) begin
                row_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < LANES; i++) begin
                if (rmio.input_we[i]) begin
                    row_q[i] <= rmio.input_data;
                end
            end
        end
    end

    // One-hot AND-OR select
    always_comb begin
        row_sel = '0;
        for (int i = 0; i < LANES; i++) begin
            if (rmio.output_re[i]) begin
                row_sel = row_sel | row_q[i];
            end
        end
    end

    //////////////////////////////
    // Row times tile
    //////////////////////////////

    // Element j is the dot product of the row with column j
    // Products and sum wrap at 16 bits
    always_comb begin
        for (int j = 0; j < ELEMS; j++) begin
            res_d[j] = '0;
            for (int k = 0; k < LANES; k++) begin
                res_d[j] = res_d[j] + elem_t'(row_sel[k] * row_q[k][j]);
            end
        end
    end

    // Result holds until the next strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rmio.output_data <= '0;
        end else if (|rmio.output_re) begin
            rmio.output_data <= res_d;
        end
    end

endmodule

// ==== rtl/rf_sync_ram.sv ====
`timescale 1ns/1ps

module rf_sync_ram import eu_pkg::*; #(
    parameter int RAM_ADDR_W = 9
) (
    input logic clk,
    bram_intf.mem port
);

    localparam int DEPTH = 2**RAM_ADDR_W;

    // Storage array, contents undefined after reset
    rf_word_t mem [DEPTH];

    //////////////////////////////
    // Write port
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (port.we) begin
            mem[port.addr] <= port.data;
        end
    end

    //////////////////////////////
    // Registered read port
    //////////////////////////////

    // Old data on a same-cycle write to the same word
    // q holds between reads
    always_ff @(posedge clk) begin
        if (port.re) begin
            port.q <= mem[port.addr];
        end
    end

endmodule

// ==== rtl/bram_intf.sv ====
`timescale 1ns/1ps

interface bram_intf import eu_pkg::*; #(
    parameter int ADDR_W = 10
) ();

    logic [ADDR_W-1:0] addr;
    rf_word_t          data;
    logic              we;
    logic              re;

    // Read data, one cycle after re
    rf_word_t          q;

    // Side issuing accesses
    modport host (
        output addr,
        output data,
        output we,
        output re,
        input  q
    );

    // Side serving accesses
    modport mem (
        input  addr,
        input  data,
        input  we,
        input  re,
        output q
    );

endinterface

// ==== rtl/rmio_intf.sv ====
`timescale 1ns/1ps

interface rmio_intf import eu_pkg::*; ();

    // Operand word toward the unit
    rf_word_t   input_data;

    // Lane store strobe, one cycle wide
    lane_mask_t input_we;

    // Result capture strobe, one cycle wide
    lane_mask_t output_re;

    // Last captured result
    rf_word_t   output_data;

    // Register file side
    modport rf (
        output input_data,
        output input_we,
        output output_re,
        input  output_data
    );

    // Execution unit side
    modport eu (
        input  input_data,
        input  input_we,
        input  output_re,
        output output_data
    );

endinterface

// ==== rtl/eu_pkg.sv ====
package eu_pkg;

    // Rows per tile, vectors per unit
    localparam int LANES = 4;

    // Elements packed into one host word
    localparam int ELEMS = 4;

    // Signed fixed-width element
    typedef logic signed [15:0] elem_t;

    // Element 0 sits in bits 15:0
    typedef elem_t [ELEMS-1:0] rf_word_t;

    // One bit per lane, one-hot when used as a strobe
    typedef logic [LANES-1:0] lane_mask_t;

endpackage

// ==== rtl/rf_map_pkg.sv ====
package rf_map_pkg;

    // Host address space
    localparam int RF_ADDR_W = 10;

    typedef logic [RF_ADDR_W-1:0] rf_addr_t;

    //////////////////////////////
    // Memory-mapped unit registers
    //////////////////////////////

    // Square-tile matrix unit, operand rows
    localparam rf_addr_t ADDR_STMM_X0 = 10'h200;
    localparam rf_addr_t ADDR_STMM_X1 = 10'h201;
    localparam rf_addr_t ADDR_STMM_X2 = 10'h202;
    localparam rf_addr_t ADDR_STMM_X3 = 10'h203;

    // Square-tile matrix unit, result rows
    localparam rf_addr_t ADDR_STMM_Y0 = 10'h208;
    localparam rf_addr_t ADDR_STMM_Y1 = 10'h209;
    localparam rf_addr_t ADDR_STMM_Y2 = 10'h20A;
    localparam rf_addr_t ADDR_STMM_Y3 = 10'h20B;

    // Mean-centering unit, operand vectors
    localparam rf_addr_t ADDR_MC_X0 = 10'h210;
    localparam rf_addr_t ADDR_MC_X1 = 10'h211;
    localparam rf_addr_t ADDR_MC_X2 = 10'h212;
    localparam rf_addr_t ADDR_MC_X3 = 10'h213;

    // Mean-centering unit, result vectors
    localparam rf_addr_t ADDR_MC_Y0 = 10'h218;
    localparam rf_addr_t ADDR_MC_Y1 = 10'h219;
    localparam rf_addr_t ADDR_MC_Y2 = 10'h21A;
    localparam rf_addr_t ADDR_MC_Y3 = 10'h21B;

    // Decode categories of one host address
    typedef enum logic [2:0] {
        RGN_RAM,
        RGN_STMM_X,
        RGN_STMM_Y,
        RGN_MC_X,
        RGN_MC_Y,
        RGN_NONE
    } rf_region_e;

    // Unit register decode, RAM range is left to the caller
    function automatic rf_region_e rf_region(rf_addr_t a);
        case (a)
            ADDR_STMM_X0, ADDR_STMM_X1, ADDR_STMM_X2, ADDR_STMM_X3: return RGN_STMM_X;
            ADDR_STMM_Y0, ADDR_STMM_Y1, ADDR_STMM_Y2, ADDR_STMM_Y3: return RGN_STMM_Y;
            ADDR_MC_X0, ADDR_MC_X1, ADDR_MC_X2, ADDR_MC_X3:         return RGN_MC_X;
            ADDR_MC_Y0, ADDR_MC_Y1, ADDR_MC_Y2, ADDR_MC_Y3:         return RGN_MC_Y;
            default:                                                return RGN_NONE;
        endcase
    endfunction

endpackage
